/* hdl/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// serial bit timing.
`define UART_CYCLES_PER_BIT 4   // clocks per bit.
`define UART_EXTRA_STOP     7   // stop bits after the first one.

// message buffer layout.
`define BUF_DEPTH  32  // bytes in the shared buffer.
`define RX_BASE    16  // first byte of the receive half.
`define TX_MAX_LEN 16  // longest message per start.

// apb address map.
`define APB_ADDR_W   8
`define APB_DATA_W   32
`define APB_WIN_LAST 8'hbc  // last window word, 32 bytes from 0x40.
`define CTRL_CLR_BIT 8      // ctrl bit that clears rx_count and frame_err.

`endif

/* hdl/uart_pkg.sv */
package uart_pkg;

  typedef logic [7:0] byte_t;      // one data byte.
  typedef logic [4:0] buf_addr_t;  // 0..15 tx half, 16..31 rx half.

  typedef struct packed {
    logic       tx_busy;    // streamer still sending.
    logic       frame_err;  // sticky until a ctrl clear.
    logic [4:0] rx_count;   // saturates at 16.
  } status_t;

  typedef enum logic [7:0] {
    REG_CTRL   = 8'h00,
    REG_STATUS = 8'h04,
    REG_WINDOW = 8'h40   // first word of the buffer window.
  } reg_off_e;

  typedef enum logic [1:0] {
    APB_IDLE, APB_WAIT_GNT, APB_WAIT_DATA, APB_DONE
  } apb_state_e;

  typedef enum logic [1:0] {
    TX_IDLE, TX_FETCH, TX_WAIT_DATA, TX_SEND
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE, RX_START, RX_DATA, RX_STOP
  } rx_state_e;

endpackage

/* hdl/buf_if.sv */
`timescale 1ns/10ps

interface buf_if import uart_pkg::*; ();

  logic      req;    // held until gnt.
  logic      we;     // 1 write, 0 read.
  buf_addr_t addr;
  byte_t     wdata;
  logic      gnt;    // one cycle, write lands at its edge.
  byte_t     rdata;  // valid the cycle after gnt.

  modport requester (output req, output we, output addr, output wdata,
                     input gnt, input rdata);

  modport arbiter (input req, input we, input addr, input wdata,
                   output gnt, output rdata);

endinterface

/* hdl/uart_tx.sv */
`timescale 1ns/10ps
`include "uart_macros.svh"

module uart_tx import uart_pkg::*; #(
  parameter int cycles_per_bit = `UART_CYCLES_PER_BIT
) (
  input  logic  clock,
  input  logic  i_rstn,
  input  byte_t i_data,
  input  logic  i_req,
  output logic  o_serial,
  output logic  o_cts,
  output logic  o_idle
);
  localparam int extra_stop = `UART_EXTRA_STOP;
  localparam int frame_bits = 10 + extra_stop;  // start, 8 data, stop, extras.
  localparam int cycle_w = (cycles_per_bit > 1) ? $clog2(cycles_per_bit) : 1;
  localparam int cursor_w = $clog2(frame_bits);
  localparam logic [cycle_w-1:0] cycle_max = cycle_w'(cycles_per_bit - 1);
  localparam logic [cursor_w-1:0] cursor_max = cursor_w'(frame_bits - 1);

  logic [cycle_w-1:0]  cycle;      // clocks left in this bit.
  logic [cursor_w-1:0] cursor;     // bits left in the frame.
  logic [8:0]          shreg;      // bit 0 is on the line.
  byte_t               hold;       // queued next byte.
  logic                pending;    // hold is full.
  logic                line_done;  // last bit time finished.
  logic                accept;
  logic                launch;

  assign line_done = (cursor == '0) && (cycle == '0);
  assign accept = i_req && o_cts;
  assign launch = line_done && pending;  // next frame starts right after the last stop.

  always_ff @(posedge clock) begin
    if (accept) begin
      hold <= i_data;
    end
  end

  always_ff @(posedge clock) begin
    if (!i_rstn) begin
      cycle   <= '0;
      cursor  <= '0;
      shreg   <= 9'h1ff;  // line idles high.
      pending <= 1'b0;
    end else begin
      if (launch) begin
        pending <= 1'b0;
      end else if (accept) begin
        pending <= 1'b1;
      end
      if (launch) begin
        cycle  <= cycle_max;
        cursor <= cursor_max;
        shreg  <= {hold, 1'b0};  // start bit goes out first.
      end else if (cycle != '0) begin
        cycle <= cycle - 1'b1;  // hold the bit.
      end else if (cursor != '0) begin
        cycle  <= cycle_max;
        cursor <= cursor - 1'b1;
        shreg  <= {1'b1, shreg[8:1]};  // stop bits fill from the top.
      end
    end
  end

  assign o_serial = shreg[0];
  assign o_cts = !pending && (cursor < cursor_w'(extra_stop));  // open in the extra stops.
  assign o_idle = line_done && !pending;

  a_idle_line_high: assert property (@(posedge clock) disable iff (!i_rstn)
    o_idle |-> o_serial);
endmodule

/* hdl/uart_rx.sv */
`timescale 1ns/10ps
`include "uart_macros.svh"

module uart_rx import uart_pkg::*; #(
  parameter int cycles_per_bit = `UART_CYCLES_PER_BIT
) (
  input  logic     clock,
  input  logic     i_rstn,
  input  logic     i_serial,
  buf_if.requester bus,
  output logic     o_frame_err_pulse,
  output logic     o_byte_stored_pulse
);
  localparam int cycle_w = (cycles_per_bit > 1) ? $clog2(cycles_per_bit) : 1;
  localparam logic [cycle_w-1:0] cycle_max = cycle_w'(cycles_per_bit - 1);
  localparam logic [cycle_w-1:0] cycle_half =
    cycle_w'((cycles_per_bit > 1) ? cycles_per_bit / 2 - 1 : 0);

  rx_state_e          state;
  logic [1:0]         sync;       // two-flop synchronizer.
  logic               line_q;     // previous synced level.
  logic [cycle_w-1:0] cycle;      // clocks to the next sample point.
  logic [2:0]         bit_idx;
  byte_t              shreg;      // lsb arrives first.
  logic [3:0]         wptr;       // wraps mod 16.
  logic               store_req;
  logic               stop_due;   // stop bit sampled this cycle.
  logic               line;

  assign line = sync[1];
  assign stop_due = (state == RX_STOP) && (cycle == '0);

  always_ff @(posedge clock) begin
    if (!i_rstn) begin
      sync   <= 2'b11;
      line_q <= 1'b1;
    end else begin
      sync   <= {sync[0], i_serial};
      line_q <= line;
    end
  end

  always_ff @(posedge clock) begin
    if ((state == RX_DATA) && (cycle == '0)) begin
      shreg <= {line, shreg[7:1]};  // mid-bit sample.
    end
  end

  always_ff @(posedge clock) begin
    if (!i_rstn) begin
      state             <= RX_IDLE;
      cycle             <= '0;
      bit_idx           <= '0;
      wptr              <= '0;
      store_req         <= 1'b0;
      o_frame_err_pulse <= 1'b0;
    end else begin
      o_frame_err_pulse <= 1'b0;
      if (store_req && bus.gnt) begin
        store_req <= 1'b0;
        wptr      <= wptr + 1'b1;
      end
      case (state)
        RX_IDLE: begin
          if (line_q && !line) begin  // falling start edge.
            state <= RX_START;
            cycle <= cycle_half;
          end
        end
        RX_START: begin
          if (cycle != '0) begin
            cycle <= cycle - 1'b1;
          end else if (!line) begin
            state   <= RX_DATA;
            cycle   <= cycle_max;
            bit_idx <= '0;
          end else begin
            state <= RX_IDLE;  // glitch, not a start bit.
          end
        end
        RX_DATA: begin
          if (cycle != '0) begin
            cycle <= cycle - 1'b1;
          end else begin
            cycle   <= cycle_max;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (cycle != '0) begin
            cycle <= cycle - 1'b1;
          end else begin
            state <= RX_IDLE;
            if (line) begin
              store_req <= 1'b1;  // good frame.
            end else begin
              o_frame_err_pulse <= 1'b1;  // byte dropped.
            end
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  assign bus.req = store_req;
  assign bus.we = 1'b1;
  assign bus.addr = buf_addr_t'(`RX_BASE) + buf_addr_t'(wptr);
  assign bus.wdata = shreg;
  assign o_byte_stored_pulse = store_req && bus.gnt;

  // the arbiter must drain a store well before the next frame ends.
  a_store_drained: assert property (@(posedge clock) disable iff (!i_rstn)
    stop_due |-> !store_req);
endmodule

/* hdl/shared_buffer.sv */
`timescale 1ns/10ps
`include "uart_macros.svh"

module shared_buffer import uart_pkg::*; (
  input  logic   clock,
  input  logic   i_rstn,
  buf_if.arbiter rx_port,
  buf_if.arbiter apb_port,
  buf_if.arbiter tx_port
);
  byte_t     mem [`BUF_DEPTH];
  logic      gnt_rx;
  logic      gnt_apb;
  logic      gnt_tx;
  logic      any_req;
  logic      sel_we;
  buf_addr_t sel_addr;
  byte_t     sel_wdata;
  byte_t     rd_q;  // shared, only the last granted reader looks.

  assign gnt_rx = rx_port.req;  // receiver cannot stall.
  assign gnt_apb = apb_port.req && !rx_port.req;
  assign gnt_tx = tx_port.req && !rx_port.req && !apb_port.req;
  assign any_req = rx_port.req || apb_port.req || tx_port.req;

  always_comb begin
    if (gnt_rx) begin
      sel_we    = rx_port.we;
      sel_addr  = rx_port.addr;
      sel_wdata = rx_port.wdata;
    end else if (gnt_apb) begin
      sel_we    = apb_port.we;
      sel_addr  = apb_port.addr;
      sel_wdata = apb_port.wdata;
    end else begin
      sel_we    = tx_port.we;
      sel_addr  = tx_port.addr;
      sel_wdata = tx_port.wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (any_req && sel_we) begin
      mem[sel_addr] <= sel_wdata;  // lands at the grant edge.
    end
  end

  always_ff @(posedge clock) begin
    if (any_req && !sel_we) begin
      rd_q <= mem[sel_addr];  // valid the cycle after gnt.
    end
  end

  assign rx_port.gnt = gnt_rx;
  assign apb_port.gnt = gnt_apb;
  assign tx_port.gnt = gnt_tx;
  assign rx_port.rdata = rd_q;
  assign apb_port.rdata = rd_q;
  assign tx_port.rdata = rd_q;

  a_gnt_onehot: assert property (@(posedge clock) disable iff (!i_rstn)
    $onehot0({gnt_rx, gnt_apb, gnt_tx}));
endmodule

/* hdl/tx_streamer.sv */
`timescale 1ns/10ps
`include "uart_macros.svh"

module tx_streamer import uart_pkg::*; #(
  parameter int cycles_per_bit = `UART_CYCLES_PER_BIT
) (
  input  logic       clock,
  input  logic       i_rstn,
  input  logic       i_start,
  input  logic [4:0] i_len,
  buf_if.requester   bus,
  output logic       o_busy,
  output logic       o_serial
);
  tx_state_e  state;
  logic [4:0] len_q;
  logic [3:0] idx;        // next tx byte, base 0.
  logic       sent_last;  // last byte handed over.
  logic       last;
  byte_t      data_q;
  logic       tx_req;
  logic       tx_cts;
  logic       tx_idle;

  assign last = ({1'b0, idx} == (len_q - 5'd1));

  always_ff @(posedge clock) begin
    if (state == TX_WAIT_DATA) begin
      data_q <= bus.rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (!i_rstn) begin
      state     <= TX_IDLE;
      len_q     <= '0;
      idx       <= '0;
      sent_last <= 1'b0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (i_start) begin
            state     <= TX_FETCH;
            len_q     <= i_len;
            idx       <= '0;
            sent_last <= 1'b0;
          end
        end
        TX_FETCH: if (bus.gnt) state <= TX_WAIT_DATA;
        TX_WAIT_DATA: state <= TX_SEND;
        TX_SEND: begin
          if (sent_last) begin
            if (tx_idle) state <= TX_IDLE;  // last frame fully out.
          end else if (tx_cts) begin
            if (last) begin
              sent_last <= 1'b1;
            end else begin
              idx   <= idx + 1'b1;
              state <= TX_FETCH;  // prefetch while the frame runs.
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  assign tx_req = (state == TX_SEND) && !sent_last;
  assign bus.req = (state == TX_FETCH);
  assign bus.we = 1'b0;
  assign bus.addr = buf_addr_t'(idx);
  assign bus.wdata = '0;
  assign o_busy = (state != TX_IDLE);

  uart_tx #(
    .cycles_per_bit(cycles_per_bit)
  ) u_tx (
    .clock   (clock),
    .i_rstn  (i_rstn),
    .i_data  (data_q),
    .i_req   (tx_req),
    .o_serial(o_serial),
    .o_cts   (tx_cts),
    .o_idle  (tx_idle)
  );
endmodule

/* hdl/apb_regs.sv */
`timescale 1ns/10ps
`include "uart_macros.svh"

module apb_regs import uart_pkg::*; (
  input  logic                   clock,
  input  logic                   i_rstn,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`APB_ADDR_W-1:0] i_paddr,
  input  logic [`APB_DATA_W-1:0] i_pwdata,
  output logic [`APB_DATA_W-1:0] o_prdata,
  output logic                   o_pready,
  output logic                   o_pslverr,
  buf_if.requester               bus,
  input  logic                   i_tx_busy,
  input  logic                   i_frame_err_pulse,
  input  logic                   i_byte_stored_pulse,
  output logic                   o_start,
  output logic [4:0]             o_len
);
  localparam logic [4:0] rx_max = 5'(`BUF_DEPTH - `RX_BASE);

  apb_state_e             state;
  status_t                status;
  logic                   frame_err_q;
  logic [4:0]             rx_count_q;
  logic [4:0]             len_q;
  logic                   access;  // access phase seen in idle.
  logic                   hit_ctrl;
  logic                   hit_status;
  logic                   hit_win;
  logic [`APB_ADDR_W-1:0] win_off;
  logic                   ctrl_wr;
  logic                   clr;
  logic [4:0]             wr_len;
  logic                   len_ok;
  buf_addr_t              addr_q;
  logic                   we_q;
  byte_t                  wdata_q;

  assign access = (state == APB_IDLE) && i_psel && i_penable;
  assign hit_ctrl = (i_paddr == REG_CTRL);
  assign hit_status = (i_paddr == REG_STATUS);
  assign hit_win = (i_paddr >= REG_WINDOW) && (i_paddr <= `APB_WIN_LAST) &&
                   (i_paddr[1:0] == 2'b00);
  assign win_off = i_paddr - REG_WINDOW;  // one byte per word.
  assign ctrl_wr = access && i_pwrite && hit_ctrl;
  assign clr = ctrl_wr && i_pwdata[`CTRL_CLR_BIT];
  assign wr_len = i_pwdata[4:0];
  assign len_ok = (wr_len != 5'd0) && (wr_len <= 5'(`TX_MAX_LEN));

  always_comb begin
    status.tx_busy   = i_tx_busy;
    status.frame_err = frame_err_q;
    status.rx_count  = rx_count_q;
  end

  always_ff @(posedge clock) begin
    if (access && hit_win) begin
      addr_q  <= win_off[6:2];
      we_q    <= i_pwrite;
      wdata_q <= i_pwdata[7:0];
    end
  end

  always_ff @(posedge clock) begin
    if (!i_rstn) begin
      state       <= APB_IDLE;
      frame_err_q <= 1'b0;
      rx_count_q  <= '0;
      len_q       <= '0;
      o_start     <= 1'b0;
    end else begin
      o_start <= 1'b0;
      if (clr) begin
        frame_err_q <= 1'b0;
        rx_count_q  <= '0;
      end else begin
        if (i_frame_err_pulse) frame_err_q <= 1'b1;  // sticky.
        if (i_byte_stored_pulse && (rx_count_q != rx_max)) begin
          rx_count_q <= rx_count_q + 1'b1;
        end
      end
      if (ctrl_wr && len_ok && !i_tx_busy && !o_start) begin  // busy start is dropped.
        o_start <= 1'b1;
        len_q   <= wr_len;
      end
      case (state)
        APB_IDLE: if (access && hit_win) state <= APB_WAIT_GNT;
        APB_WAIT_GNT: if (bus.gnt) state <= we_q ? APB_DONE : APB_WAIT_DATA;
        APB_WAIT_DATA: state <= APB_IDLE;
        APB_DONE: state <= APB_IDLE;
        default: state <= APB_IDLE;
      endcase
    end
  end

  always_comb begin
    o_prdata = '0;
    if (state == APB_WAIT_DATA) begin
      o_prdata = {{(`APB_DATA_W - 8){1'b0}}, bus.rdata};
    end else if (access && hit_status) begin
      o_prdata = {{(`APB_DATA_W - 7){1'b0}}, status};
    end else if (access && hit_ctrl) begin
      o_prdata = {{(`APB_DATA_W - 5){1'b0}}, len_q};  // last started length.
    end
  end

  assign o_pready = (access && !hit_win) || (state == APB_WAIT_DATA) || (state == APB_DONE);
  assign o_pslverr = access && !hit_ctrl && !hit_status && !hit_win;
  assign bus.req = (state == APB_WAIT_GNT);
  assign bus.we = we_q;
  assign bus.addr = addr_q;
  assign bus.wdata = wdata_q;
  assign o_len = len_q;
endmodule

/* hdl/uart_loop_top.sv */
`timescale 1ns/10ps
`include "uart_macros.svh"

module uart_loop_top (
  input  logic                   clock,
  input  logic                   i_rstn,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`APB_ADDR_W-1:0] i_paddr,
  input  logic [`APB_DATA_W-1:0] i_pwdata,
  output logic [`APB_DATA_W-1:0] o_prdata,
  output logic                   o_pready,
  output logic                   o_pslverr,
  output logic                   o_serial,
  input  logic                   i_serial
);
  logic       start;
  logic [4:0] len;
  logic       tx_busy;
  logic       frame_err_pulse;
  logic       byte_stored_pulse;

  buf_if rx_bus ();   // highest priority.
  buf_if apb_bus ();
  buf_if tx_bus ();   // lowest priority.

  apb_regs u_regs (
    .clock              (clock),
    .i_rstn             (i_rstn),
    .i_psel             (i_psel),
    .i_penable          (i_penable),
    .i_pwrite           (i_pwrite),
    .i_paddr            (i_paddr),
    .i_pwdata           (i_pwdata),
    .o_prdata           (o_prdata),
    .o_pready           (o_pready),
    .o_pslverr          (o_pslverr),
    .bus                (apb_bus.requester),
    .i_tx_busy          (tx_busy),
    .i_frame_err_pulse  (frame_err_pulse),
    .i_byte_stored_pulse(byte_stored_pulse),
    .o_start            (start),
    .o_len              (len)
  );

  shared_buffer u_buf (
    .clock   (clock),
    .i_rstn  (i_rstn),
    .rx_port (rx_bus.arbiter),
    .apb_port(apb_bus.arbiter),
    .tx_port (tx_bus.arbiter)
  );

  tx_streamer #(.cycles_per_bit(`UART_CYCLES_PER_BIT)) u_stream (
    .clock   (clock),
    .i_rstn  (i_rstn),
    .i_start (start),
    .i_len   (len),
    .bus     (tx_bus.requester),
    .o_busy  (tx_busy),
    .o_serial(o_serial)
  );

  uart_rx #(.cycles_per_bit(`UART_CYCLES_PER_BIT)) u_rx (
    .clock              (clock),
    .i_rstn             (i_rstn),
    .i_serial           (i_serial),
    .bus                (rx_bus.requester),
    .o_frame_err_pulse  (frame_err_pulse),
    .o_byte_stored_pulse(byte_stored_pulse)
  );
endmodule

/* tb/tb_uart_loop.sv */
`timescale 1ns/10ps
`include "uart_macros.svh"

module tb_uart_loop import uart_pkg::*; ();
  localparam logic [31:0] rnd_mark = 32'h100;  // payload byte marker, window lines only.
  localparam int apb_limit = 50;               // cycles allowed for o_pready.
  localparam int poll_limit = 3000;            // status reads per poll line.

  logic                   clock;
  logic                   i_rstn;
  logic                   i_psel;
  logic                   i_penable;
  logic                   i_pwrite;
  logic [`APB_ADDR_W-1:0] i_paddr;
  logic [`APB_DATA_W-1:0] i_pwdata;
  logic [`APB_DATA_W-1:0] o_prdata;
  logic                   o_pready;
  logic                   o_pslverr;
  logic                   o_serial;
  logic                   i_serial;
  logic                   inject;    // bit-banger owns the line.
  logic                   bang_bit;
  integer                 seed;
  byte_t                  sent_q[$]; // payload in send order.
  logic [`APB_DATA_W-1:0] rd_data;   // last completed access.
  logic                   rd_err;
  int                     rd_lat;    // cycles waited after access phase.

  assign i_serial = inject ? bang_bit : o_serial;  // loopback by default.

  uart_loop_top dut (
    .clock    (clock),
    .i_rstn   (i_rstn),
    .i_psel   (i_psel),
    .i_penable(i_penable),
    .i_pwrite (i_pwrite),
    .i_paddr  (i_paddr),
    .i_pwdata (i_pwdata),
    .o_prdata (o_prdata),
    .o_pready (o_pready),
    .o_pslverr(o_pslverr),
    .o_serial (o_serial),
    .i_serial (i_serial)
  );

  always #2 clock = ~clock;  // 4 ns period.

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0d ns: %s got 0x%02h expected 0x%02h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0d ns: %s got 0x%02h expected 0x%02h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0d ns: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  function automatic logic is_window(input logic [7:0] addr);
    return (addr >= 8'h40) && (addr <= 8'hbc) && (addr[1:0] == 2'b00);  // 32 byte words.
  endfunction

  function automatic logic is_mapped(input logic [7:0] addr);
    return (addr == 8'h00) || (addr == 8'h04) || is_window(addr);
  endfunction

  // one apb transfer, entered and left 1 ns after a rising edge.
  task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] data);
    int waited;
    waited = 0;
    i_psel    = 1'b1;  // setup phase.
    i_penable = 1'b0;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = data;
    @(posedge clock);
    #1;
    i_penable = 1'b1;  // access phase.
    @(negedge clock);
    while (!o_pready && (waited < apb_limit)) begin
      waited++;
      @(negedge clock);
    end
    if (!o_pready) abort_run($sformatf("o_pready never rose for address 0x%02h", addr));
    rd_data = o_prdata;
    rd_err  = o_pslverr;
    rd_lat  = waited;
    @(posedge clock);
    #1;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    check_bit($sformatf("o_pslverr at 0x%02h", addr), rd_err, !is_mapped(addr));
    if (is_window(addr) && (rd_lat < 2)) begin
      abort_run($sformatf("window access at 0x%02h ended after %0d cycles", addr, rd_lat));
    end else if (!is_window(addr) && (rd_lat != 0)) begin
      abort_run($sformatf("register access at 0x%02h waited %0d cycles", addr, rd_lat));
    end
  endtask

  // start, data lsb first, then a low stop bit.
  task automatic inject_bad_frame(input byte_t value);
    logic [9:0] frame;
    frame  = {1'b0, value, 1'b0};
    inject = 1'b1;
    for (int b = 0; b < 10; b++) begin
      bang_bit = frame[b];
      repeat (`UART_CYCLES_PER_BIT) @(posedge clock);
      #1;
    end
    bang_bit = 1'b1;  // idle before giving the line back.
    repeat (`UART_CYCLES_PER_BIT * 8) @(posedge clock);
    #1;
    inject = 1'b0;
  endtask

  task automatic run_line(input logic [7:0] op, input logic [7:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
    logic [31:0] rnd_word;
    byte_t       want;
    int          polls;
    polls = 0;
    case (op)
      "W": begin
        if (is_window(addr) && (data == rnd_mark)) begin
          rnd_word = $random(seed);
          sent_q.push_back(rnd_word[7:0]);  // expected on the rx side.
          bus_access(1'b1, addr, {24'h0, rnd_word[7:0]});
        end else begin
          bus_access(1'b1, addr, data);
        end
      end
      "R": begin
        bus_access(1'b0, addr, '0);
        if (addr == REG_STATUS) begin
          check_status("STATUS", status_t'(rd_data[6:0]), status_t'(exp[6:0]));
        end else if (is_window(addr)) begin
          if (exp == rnd_mark) begin
            if (sent_q.size() == 0) abort_run("no sent byte left to compare against");
            want = sent_q.pop_front();
          end else begin
            want = exp[7:0];
          end
          check_byte($sformatf("window 0x%02h", addr), rd_data[7:0], want);
        end
      end
      "P": begin
        bus_access(1'b0, addr, '0);
        while ((rd_data[6:0] !== exp[6:0]) && (polls < poll_limit)) begin
          polls++;
          bus_access(1'b0, addr, '0);
        end
        if (rd_data[6:0] !== exp[6:0]) begin
          abort_run($sformatf("STATUS stayed at 0x%02h while waiting for 0x%02h",
                              rd_data[6:0], exp[6:0]));
        end
      end
      "B": inject_bad_frame(data[7:0]);
      default: abort_run($sformatf("unknown stimulus opcode %s", op));
    endcase
  endtask

  initial begin : watchdog
    #(2_000_000);
    abort_run("simulation ran past its time limit");
  end

  initial begin
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [31:0] exp;
    clock     = 1'b0;
    i_rstn    = 1'b0;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_paddr   = '0;
    i_pwdata  = '0;
    inject    = 1'b0;
    bang_bit  = 1'b1;
    seed      = 32'hef0e_ab48;
    repeat (3) @(posedge clock);
    #1;
    i_rstn = 1'b1;
    @(negedge clock);
    check_bit("o_serial", o_serial, 1'b1);  // line idles high.
    check_bit("o_pready", o_pready, 1'b0);
    check_bit("o_pslverr", o_pslverr, 1'b0);
    @(posedge clock);
    #1;
    fd = $fopen("tb/uart_stimulus.txt", "r");
    if (fd == 0) abort_run("cannot open tb/uart_stimulus.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      op = 8'h00;
      n = $sscanf(line, "%s %h %h %h", op, addr, data, exp);
      if ((n >= 1) && (op == "#")) begin
        continue;  // column notes.
      end else if (n == 4) begin
        run_line(op, addr, data, exp);
      end else if (n > 0) begin
        abort_run($sformatf("malformed stimulus line: %s", line));
      end
    end
    $fclose(fd);
    $display("** PASS **");
    $finish;
  end
endmodule

/* tb/uart_stimulus.txt */
# op addr data expect, all hex. W write, R read and check, P poll STATUS, B bad frame
# on window lines a data or expect of 100 means a random payload byte in send order
R 04 0 0
W 40 a5 0
W 7c 3c 0
W 80 5a 0
W bc c3 0
R 40 0 a5
R 7c 0 3c
R 80 0 5a
R bc 0 c3
W 40 100 0
W 44 100 0
W 48 100 0
W 4c 100 0
W 50 100 0
W 00 5 0
P 04 0 05
R 80 0 100
R 84 0 100
R 88 0 100
R 8c 0 100
R 90 0 100
B 00 96 0
P 04 0 25
W 00 100 0
R 04 0 0
R 08 0 0
W 20 ff 0
R c0 0 0
R 42 0 0
W 00 2 0
W 00 3 0
P 04 0 02
R 04 0 02

/* sources.f */
+incdir+hdl
hdl/uart_pkg.sv
hdl/buf_if.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/shared_buffer.sv
hdl/tx_streamer.sv
hdl/apb_regs.sv
hdl/uart_loop_top.sv
tb/tb_uart_loop.sv

/* Makefile */
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module tb_uart_loop -o sim

run: build
	./obj_dir/sim | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module tb_uart_loop

clean:
	rm -rf obj_dir $(LOG)
